//--- Makefile
LOG = sim.log

.PHONY: compile run clean

compile:
	verilator --binary --assert -Wno-fatal -j 0 --top-module tb_nand_ecc_gen -f sim.f -o tb_nand_ecc_gen

run: compile
	-./obj_dir/tb_nand_ecc_gen > $(LOG) 2>&1
	cat $(LOG)
	! grep -q "Simulation FAILED" $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- design/ecc_accum.sv
`default_nettype none

module ecc_accum (
	input  wire logic            clk,
	input  wire logic            rst,
	input  wire logic            in_valid,
	output logic                 in_ready,
	input  wire ecc_pkg::byte_t  in_data,
	ecc_page_if.src              page
);

	ecc_pkg::page_idx_t   cnt;
	ecc_pkg::col_par_t    col_acc;
	ecc_pkg::row_par_t    row_acc;
	ecc_pkg::col_par_t    col_next;
	ecc_pkg::row_par_t    row_next;
	logic                 last_idx;
	logic                 take;

	assign last_idx = (cnt == ecc_pkg::page_idx_t'(ecc_pkg::PAGE_BYTES - 1));
	assign take     = in_valid && in_ready;

	// Stall only the closing byte of a page while the previous snapshot waits
	assign in_ready = !(page.valid && !page.ready && last_idx);

	//////////////////////////////
	// Running parities
	//////////////////////////////

	assign col_next = col_acc ^ in_data;

	always_comb
	begin
		row_next      = row_acc;
		row_next[cnt] = ^in_data;
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			cnt     <= '0;
			col_acc <= '0;
			row_acc <= '0;
		end
		else if (take)
		begin
			cnt <= cnt + 1'b1;
			if (last_idx)
			begin
				col_acc <= '0;
				row_acc <= '0;
			end
			else
			begin
				col_acc <= col_next;
				row_acc <= row_next;
			end
		end
	end

	//////////////////////////////
	// Finished page snapshot
	//////////////////////////////

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			page.valid <= 1'b0;
		else if (take && last_idx)
			page.valid <= 1'b1;
		else if (page.ready)
			page.valid <= 1'b0;
	end

	// Includes the closing byte itself
	always_ff @(posedge clk)
	begin
		if (take && last_idx)
		begin
			page.col_par <= col_next;
			page.row_par <= row_next;
		end
	end

endmodule

`default_nettype wire

//--- design/ecc_code_if.sv
`default_nettype none

interface ecc_code_if;

	logic           valid;
	logic           ready;
	ecc_pkg::cp_t   cp;
	ecc_pkg::rp_t   rp;

	modport src
	(
		output valid,
		output cp,
		output rp,
		input  ready
	);

	modport dst
	(
		input  valid,
		input  cp,
		input  rp,
		output ready
	);

endinterface

`default_nettype wire

//--- design/ecc_emit.sv
`default_nettype none

module ecc_emit (
	input  wire logic      clk,
	input  wire logic      rst,
	ecc_code_if.dst        code,
	output logic           ecc_valid,
	input  wire logic      ecc_ready,
	output ecc_pkg::byte_t ecc_byte,
	output logic           ecc_last
);

	ecc_pkg::emit_state_t   state;
	ecc_pkg::cp_t           cp_q;
	ecc_pkg::rp_t           rp_q;
	logic                   load;

	// Take the next code while the cp byte leaves, so codes run back to back
	assign code.ready = (state == ecc_pkg::EMIT_IDLE) ||
		((state == ecc_pkg::EMIT_CP) && ecc_ready);
	assign load       = code.valid && code.ready;

	assign ecc_valid = (state != ecc_pkg::EMIT_IDLE);
	assign ecc_last  = (state == ecc_pkg::EMIT_CP);

	always_comb
	begin
		case (state)
			ecc_pkg::EMIT_RP_LO: ecc_byte = rp_q[7:0];
			ecc_pkg::EMIT_RP_HI: ecc_byte = rp_q[15:8];
			ecc_pkg::EMIT_CP:    ecc_byte = cp_q;
			default:             ecc_byte = '0;
		endcase
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			state <= ecc_pkg::EMIT_IDLE;
		else
		begin
			case (state)
				ecc_pkg::EMIT_IDLE:
					if (load)
						state <= ecc_pkg::EMIT_RP_LO;
				ecc_pkg::EMIT_RP_LO:
					if (ecc_ready)
						state <= ecc_pkg::EMIT_RP_HI;
				ecc_pkg::EMIT_RP_HI:
					if (ecc_ready)
						state <= ecc_pkg::EMIT_CP;
				default:
					if (ecc_ready)
						state <= load ? ecc_pkg::EMIT_RP_LO : ecc_pkg::EMIT_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (load)
		begin
			cp_q <= code.cp;
			rp_q <= code.rp;
		end
	end

endmodule

`default_nettype wire

//--- design/ecc_fold.sv
`default_nettype none

module ecc_fold (
	input  wire logic  clk,
	input  wire logic  rst,
	ecc_page_if.dst    page,
	ecc_code_if.src    code
);

	ecc_pkg::cp_t   cp_fold;
	ecc_pkg::rp_t   rp_fold;

	// Output register empty or being taken this cycle
	assign page.ready = !code.valid || code.ready;

	// Even bit of a pair collects indices with bit k clear, odd bit those with it set
	always_comb
	begin
		cp_fold = '0;
		rp_fold = '0;
		for (int k = 0; k < ecc_pkg::IDX_BITS; k++)
		begin
			for (int i = 0; i < ecc_pkg::PAGE_BYTES; i++)
			begin
				if (i[k])
					rp_fold[2*k+1] = rp_fold[2*k+1] ^ page.row_par[i];
				else
					rp_fold[2*k] = rp_fold[2*k] ^ page.row_par[i];
			end
		end
		for (int k = 0; k < ecc_pkg::COL_BITS; k++)
		begin
			for (int j = 0; j < $bits(ecc_pkg::col_par_t); j++)
			begin
				if (j[k])
					cp_fold[2*k+1] = cp_fold[2*k+1] ^ page.col_par[j];
				else
					cp_fold[2*k] = cp_fold[2*k] ^ page.col_par[j];
			end
		end
		cp_fold[2*ecc_pkg::COL_BITS+1 -: 2] = 2'b11;
		rp_fold[2*ecc_pkg::IDX_BITS+1 -: 2] = 2'b11;
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			code.valid <= 1'b0;
		else if (page.valid && page.ready)
			code.valid <= 1'b1;
		else if (code.ready)
			code.valid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (page.valid && page.ready)
		begin
			code.cp <= cp_fold;
			code.rp <= rp_fold;
		end
	end

endmodule

`default_nettype wire

//--- design/ecc_page_if.sv
`default_nettype none

interface ecc_page_if;

	logic                valid;
	logic                ready;
	ecc_pkg::col_par_t   col_par;
	ecc_pkg::row_par_t   row_par;

	modport src
	(
		output valid,
		output col_par,
		output row_par,
		input  ready
	);

	modport dst
	(
		input  valid,
		input  col_par,
		input  row_par,
		output ready
	);

endinterface

`default_nettype wire

//--- design/ecc_pkg.sv
`default_nettype none

package ecc_pkg;

	//////////////////////////////
	// Page geometry
	//////////////////////////////

	localparam int PAGE_BYTES = 128;
	localparam int IDX_BITS   = 7;

	// Bit pairs in the column code, one per column index bit
	localparam int COL_BITS   = 3;

	//////////////////////////////
	// Vector types
	//////////////////////////////

	typedef logic [7:0]            byte_t;
	typedef logic [IDX_BITS-1:0]   page_idx_t;
	typedef logic [7:0]            col_par_t;
	typedef logic [PAGE_BYTES-1:0] row_par_t;

	// Top two bits of each code are fixed at one
	typedef logic [2*COL_BITS+1:0] cp_t;
	typedef logic [2*IDX_BITS+1:0] rp_t;

	// Emit order is rp low, rp high, then cp
	typedef enum logic [1:0]
	{
		EMIT_IDLE,
		EMIT_RP_LO,
		EMIT_RP_HI,
		EMIT_CP
	} emit_state_t;

endpackage

`default_nettype wire

//--- design/nand_ecc_gen.sv
`default_nettype none

module nand_ecc_gen (
	input  wire logic            clk,
	input  wire logic            rst,

	// Page bytes in
	input  wire logic            in_valid,
	output logic                 in_ready,
	input  wire ecc_pkg::byte_t  in_data,

	// Code bytes out, rp low first
	output logic                 ecc_valid,
	input  wire logic            ecc_ready,
	output ecc_pkg::byte_t       ecc_byte,
	output logic                 ecc_last
);

	ecc_page_if page_if ();
	ecc_code_if code_if ();

	//////////////////////////////
	// Pipeline stages
	//////////////////////////////

	ecc_accum u_accum (
		.clk      (clk),
		.rst      (rst),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.in_data  (in_data),
		.page     (page_if.src)
	);

	ecc_fold u_fold (
		.clk  (clk),
		.rst  (rst),
		.page (page_if.dst),
		.code (code_if.src)
	);

	ecc_emit u_emit (
		.clk       (clk),
		.rst       (rst),
		.code      (code_if.dst),
		.ecc_valid (ecc_valid),
		.ecc_ready (ecc_ready),
		.ecc_byte  (ecc_byte),
		.ecc_last  (ecc_last)
	);

endmodule

`default_nettype wire

//--- sim.f
design/ecc_pkg.sv
design/ecc_page_if.sv
design/ecc_code_if.sv
design/ecc_accum.sv
design/ecc_fold.sv
design/ecc_emit.sv
design/nand_ecc_gen.sv
sim/nand_ecc_chk.sv
sim/tb_nand_ecc_gen.sv

//--- sim/ecc_patterns.hex
// One page per line: 128 data bytes with byte 0 leftmost,
// then the expected code bytes rp[7:0], rp[15:8] and cp
000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000c0c0
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff00c0c0
000000000000000000000000000000000000000000000000000000000000000000000000002000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000066d9e6
55aa551355aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55aa80aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55aa55470ff0ff

//--- sim/nand_ecc_chk.sv
`default_nettype none

module nand_ecc_chk (
	input wire logic           clk,
	input wire logic           rst,
	input wire logic           ecc_valid,
	input wire logic           ecc_ready,
	input wire ecc_pkg::byte_t ecc_byte,
	input wire logic           ecc_last
);

	logic [1:0] xfer_pos;

	// Slot of the next transfer within its three-byte code
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			xfer_pos <= 2'd0;
		else if (ecc_valid && ecc_ready)
			xfer_pos <= (xfer_pos == 2'd2) ? 2'd0 : xfer_pos + 2'd1;
	end

	assert property (@(posedge clk) disable iff (rst)
		ecc_valid && !ecc_ready |=> ecc_valid && $stable(ecc_byte) && $stable(ecc_last))
	else
		$error("ecc_byte or ecc_last changed during an output stall");

	assert property (@(posedge clk) disable iff (rst)
		ecc_valid && ecc_ready |-> ecc_last == (xfer_pos == 2'd2))
	else
		$error("ecc_last is not on every third output transfer");

	// cp byte always carries its fixed top bits
	assert property (@(posedge clk) disable iff (rst)
		ecc_last |-> ecc_byte[7:6] == 2'b11)
	else
		$error("ecc_byte[7:6] is not 11 on the last code byte");

	assert property (@(posedge clk) rst |-> !ecc_valid)
	else
		$error("ecc_valid is high during reset");

endmodule

`default_nettype wire

//--- sim/tb_nand_ecc_gen.sv
`default_nettype none

module tb_nand_ecc_gen;

	localparam int NUM_PAGES   = 4;
	localparam int CODE_BYTES  = 3;
	localparam int WORD_BITS   = 8 * (ecc_pkg::PAGE_BYTES + CODE_BYTES);
	localparam int DRIVE_DELAY = 1;
	localparam int MAX_CYCLES  = NUM_PAGES * ecc_pkg::PAGE_BYTES * 4 + 200;

	logic                 clk = 1'b0;
	logic                 rst;
	logic                 in_valid;
	logic                 in_ready;
	logic                 ecc_valid;
	logic                 ecc_ready;
	logic                 ecc_last;
	ecc_pkg::byte_t       in_data;
	ecc_pkg::byte_t       ecc_byte;
	logic [WORD_BITS-1:0] patterns [NUM_PAGES];
	ecc_pkg::byte_t       expected_q [$];
	logic [31:0]          lfsr;
	logic                 stall_out;
	int                   out_count;
	int                   cycle_count;

	nand_ecc_gen u_nand_ecc_gen (.*);

	bind nand_ecc_gen nand_ecc_chk u_chk (.clk(clk), .rst(rst), .ecc_valid(ecc_valid),
		.ecc_ready(ecc_ready), .ecc_byte(ecc_byte), .ecc_last(ecc_last));

	initial
		forever #4 clk = ~clk;

	// Fibonacci LFSR with taps at x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	function automatic logic lfsr_bit();
		lfsr = lfsr_step(lfsr);
		return lfsr[0];
	endfunction

	task automatic stop_run();
		$display("Simulation FAILED");
		$fatal(1, "Run stopped at the first error");
	endtask

	// One clock with the inputs already driven
	task automatic run_cycle(output logic taken);
		ecc_ready = stall_out ? lfsr_bit() : 1'b1;
		@(negedge clk);
		taken = in_valid && in_ready;
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	task automatic send_page(input int page, input logic gaps);
		logic taken;
		for (int idx = 0; idx < ecc_pkg::PAGE_BYTES; idx++)
		begin
			// LFSR only stepped when gaps are enabled
			if (gaps && lfsr_bit())
			begin
				in_valid = 1'b0;
				run_cycle(taken);
			end
			in_valid = 1'b1;
			in_data  = patterns[page][WORD_BITS-1-8*idx -: 8];
			taken    = 1'b0;
			while (!taken)
				run_cycle(taken);
		end
	endtask

	task automatic check_output();
		ecc_pkg::byte_t exp_byte;
		logic           exp_last;
		assert (expected_q.size() > 0)
		else
		begin
			$display("Code byte %h came out with no page waiting for a code", ecc_byte);
			stop_run();
		end
		exp_byte = expected_q.pop_front();
		exp_last = (out_count % CODE_BYTES) == CODE_BYTES - 1;
		assert (ecc_byte == exp_byte && ecc_last == exp_last)
		else
		begin
			$display("[FAIL] %0t: page %0d code byte %0d is %h last %b, expected %h last %b",
				$time, out_count / CODE_BYTES, out_count % CODE_BYTES,
				ecc_byte, ecc_last, exp_byte, exp_last);
			stop_run();
		end
		out_count++;
	endtask

	// Output transfers sampled away from the clock edge
	always @(negedge clk)
	begin
		if (!rst && ecc_valid && ecc_ready)
			check_output();
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count > MAX_CYCLES)
		begin
			$display("Timeout after %0d cycles with %0d of %0d code bytes received",
				cycle_count, out_count, NUM_PAGES * CODE_BYTES);
			stop_run();
		end
	end

	initial
	begin
		logic taken;
		rst         = 1'b1;
		in_valid    = 1'b0;
		in_data     = '0;
		ecc_ready   = 1'b1;
		stall_out   = 1'b0;
		lfsr        = 32'ha9c2da59;
		out_count   = 0;
		cycle_count = 0;
		$readmemh("sim/ecc_patterns.hex", patterns);
		for (int p = 0; p < NUM_PAGES; p++)
		begin
			assert (patterns[p][7:0] >= 8'hc0)
			else
			begin
				$display("Pattern line %0d has no valid cp byte, the pattern file is bad", p);
				stop_run();
			end
		end
		repeat (2) @(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b0;

		assert (in_ready && !ecc_valid)
		else
		begin
			$display("[FAIL] %0t: after reset in_ready is %b and ecc_valid is %b, expected 1 and 0",
				$time, in_ready, ecc_valid);
			stop_run();
		end

		// Pages back to back with input gaps and output stalls on the last one
		for (int p = 0; p < NUM_PAGES; p++)
		begin
			for (int j = 0; j < CODE_BYTES; j++)
				expected_q.push_back(patterns[p][8*CODE_BYTES-1-8*j -: 8]);
			stall_out = (p == NUM_PAGES - 1);
			send_page(p, p == NUM_PAGES - 1);
		end
		in_valid = 1'b0;
		while (out_count < NUM_PAGES * CODE_BYTES)
			run_cycle(taken);
		repeat (4) run_cycle(taken);

		// Pipeline drained once every code byte has left
		assert (!ecc_valid && in_ready)
		else
		begin
			$display("[FAIL] %0t: pipeline not idle at the end, ecc_valid %b in_ready %b",
				$time, ecc_valid, in_ready);
			stop_run();
		end

		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire
